// File: hw/rp_pkg.sv
package rp_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADC_RAW_W = 16;  // Raw ADC word, 2 LSBs reserved
  localparam int SMP_W     = 14;  // Sample width
  localparam int SUM_W     = 15;  // Level + offset before saturation
  localparam int AXI_AW    = 8;
  localparam int AXI_DW    = 32;
  localparam int NUM_CH    = 2;   // Analog channels A and B
  localparam int NUM_PWM   = 4;
  localparam int NUM_EXP   = 4;   // Expansion inputs with edge counters
  localparam int LED_W     = 8;

  typedef logic        [ADC_RAW_W-1:0] adc_raw_t;
  typedef logic signed [SMP_W-1:0]     sample_t;    // Two's complement
  typedef logic        [SMP_W-1:0]     dac_code_t;  // Negative-slope offset code
  typedef logic        [7:0]           duty_t;

  // Master side of AXI4-Lite
  typedef struct packed {
    logic [AXI_AW-1:0]   awaddr;
    logic                awvalid;
    logic [AXI_DW-1:0]   wdata;
    logic [AXI_DW/8-1:0] wstrb;    // Whole words only
    logic                wvalid;
    logic                bready;
    logic [AXI_AW-1:0]   araddr;
    logic                arvalid;
    logic                rready;
  } axil_req_t;

  // Slave side of AXI4-Lite
  typedef struct packed {
    logic              awready;
    logic              wready;
    logic [1:0]        bresp;
    logic              bvalid;
    logic              arready;
    logic [AXI_DW-1:0] rdata;
    logic [1:0]        rresp;
    logic              rvalid;
  } axil_rsp_t;

  // Register-held configuration
  typedef struct packed {
    logic                     digital_loop;  // ADC reads DAC values
    logic [LED_W-1:0]         led;
    sample_t [NUM_CH-1:0]     dac_level;
    sample_t [NUM_CH-1:0]     dac_offset;
    duty_t   [NUM_PWM-1:0]    pwm_duty;
  } rp_cfg_t;

  ////////////////////////////////////////////////////////////////////////////
  // Register map, region in address bits 7:6
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [1:0] RGN_HK  = 2'd0;
  localparam logic [1:0] RGN_DAC = 2'd1;
  localparam logic [1:0] RGN_PWM = 2'd2;
  localparam logic [1:0] RGN_CNT = 2'd3;

  localparam logic [AXI_AW-1:0] REG_ID          = 8'h00;
  localparam logic [AXI_AW-1:0] REG_CTRL        = 8'h04;  // [0] loop, [15:8] LEDs
  localparam logic [AXI_AW-1:0] REG_ADC_A       = 8'h08;
  localparam logic [AXI_AW-1:0] REG_ADC_B       = 8'h0C;
  localparam logic [AXI_AW-1:0] REG_DAC_LEVEL_A = 8'h40;
  localparam logic [AXI_AW-1:0] REG_DAC_LEVEL_B = 8'h44;
  localparam logic [AXI_AW-1:0] REG_DAC_OFS_A   = 8'h48;
  localparam logic [AXI_AW-1:0] REG_DAC_OFS_B   = 8'h4C;
  localparam logic [AXI_AW-1:0] REG_PWM         = 8'h80;  // One word per output
  localparam logic [AXI_AW-1:0] REG_CNT         = 8'hC0;  // One word per input

  localparam logic [AXI_DW-1:0] RP_ID = 32'h5250_0A01;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  localparam dac_code_t DAC_CODE_ZERO = 14'h1FFF;  // Mid-scale, sample 0

  // Negative-slope code <-> two's complement, same in both directions
  function automatic logic [SMP_W-1:0] flip_code(input logic [SMP_W-1:0] w);
    return {w[SMP_W-1], ~w[SMP_W-2:0]};
  endfunction

endpackage

// File: hw/rp_pwm.sv
`timescale 1ns/1ns

module rp_pwm
  import rp_pkg::*;
(
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  input  duty_t [NUM_PWM-1:0]   duty_i,   // High cycles per 256
  output logic  [NUM_PWM-1:0]   pwm_o
);

  logic [$bits(duty_t)-1:0] per_q;        // Shared period counter
  logic [NUM_PWM-1:0]       pwm_q;

  ////////////////////////////////////////////////////////////////////////////
  // Period counter
  ////////////////////////////////////////////////////////////////////////////

  // Free-running, wraps every 256 cycles
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      per_q <= '0;
    else
      per_q <= per_q + 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare stage
  ////////////////////////////////////////////////////////////////////////////

  // High while counter below duty, duty 0 never high
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      pwm_q <= '0;
    else
    begin
      for (int i = 0; i < NUM_PWM; i++)
        pwm_q[i] <= (per_q < duty_i[i]);
    end
  end

  assign pwm_o = pwm_q;                   // Registered, glitch-free

endmodule

// File: hw/rp_event_counter.sv
`timescale 1ns/1ns

module rp_event_counter
  import rp_pkg::*;
#(
  parameter int CNT_W = 32
)
(
  input  logic                            adc_clk,
  input  logic                            rst_n_i,
  input  logic [NUM_EXP-1:0]              exp_i,   // Asynchronous pins
  input  logic [NUM_EXP-1:0]              clr_i,   // One pulse per counter
  output logic [NUM_EXP-1:0][CNT_W-1:0]   cnt_o
);

  logic [NUM_EXP-1:0]            sync1_q;
  logic [NUM_EXP-1:0]            sync2_q;
  logic [NUM_EXP-1:0]            last_q;   // Previous synced level
  logic [NUM_EXP-1:0]            rise;
  logic [NUM_EXP-1:0][CNT_W-1:0] cnt_q;

  ////////////////////////////////////////////////////////////////////////////
  // Synchroniser and edge detect
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      sync1_q <= '0;
      sync2_q <= '0;
      last_q  <= '0;
    end
    else
    begin
      sync1_q <= exp_i;                   // Two-flop synchroniser
      sync2_q <= sync1_q;
      last_q  <= sync2_q;
    end
  end

  assign rise = sync2_q & ~last_q;

  ////////////////////////////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////////////////////////////

  // Edge counted on third clock after the pin changes
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      cnt_q <= '0;
    else
    begin
      for (int i = 0; i < NUM_EXP; i++)
        if (clr_i[i])
          cnt_q[i] <= '0;                 // Clear wins over an edge
        else if (rise[i])
          cnt_q[i] <= cnt_q[i] + 1'b1;    // Wraps at the top
    end
  end

  assign cnt_o = cnt_q;

endmodule

// File: hw/rp_adc_frontend.sv
`timescale 1ns/1ns

module rp_adc_frontend
  import rp_pkg::*;
(
  input  logic                   adc_clk,
  input  logic                   rst_n_i,
  input  adc_raw_t [NUM_CH-1:0]  adc_dat_i,  // Negative-slope, 16 bit
  input  logic                   loop_i,     // Digital loopback
  input  sample_t  [NUM_CH-1:0]  dac_smp_i,
  output sample_t  [NUM_CH-1:0]  adc_smp_o
);

  logic [NUM_CH-1:0][SMP_W-1:0] raw_q;  // Top 14 bits per channel

  ////////////////////////////////////////////////////////////////////////////
  // Input register
  ////////////////////////////////////////////////////////////////////////////

  // Low two bits reserved by the 16-bit ADC format
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      raw_q <= {NUM_CH{DAC_CODE_ZERO}};      // Reads as sample 0
    else
    begin
      for (int ch = 0; ch < NUM_CH; ch++)
        raw_q[ch] <= adc_dat_i[ch][ADC_RAW_W-1 -: SMP_W];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Code conversion and loopback
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int ch = 0; ch < NUM_CH; ch++)
    begin
      if (loop_i)
        adc_smp_o[ch] = dac_smp_i[ch];       // Same channel of the DAC
      else
        adc_smp_o[ch] = flip_code(raw_q[ch]); // Sign kept, rest inverted
    end
  end

endmodule

// File: hw/rp_dac_backend.sv
`timescale 1ns/1ns

module rp_dac_backend
  import rp_pkg::*;
(
  input  logic                    adc_clk,
  input  logic                    rst_n_i,
  input  sample_t   [NUM_CH-1:0]  level_i,
  input  sample_t   [NUM_CH-1:0]  offset_i,
  output sample_t   [NUM_CH-1:0]  dac_smp_o,  // Saturated, for loopback
  output dac_code_t [NUM_CH-1:0]  dac_dat_o
);

  for (genvar ch = 0; ch < NUM_CH; ch++)
  begin : g_ch
    logic [SUM_W-1:0] sum;   // Two's complement, one guard bit
    logic [SMP_W-1:0] sat;
    dac_code_t        dac_q;

    ////////////////////////////////////////////////////////////////////////
    // Sum and saturation
    ////////////////////////////////////////////////////////////////////////

    // Sign-extend both terms by one bit
    assign sum = {level_i[ch][SMP_W-1], level_i[ch]}
               + {offset_i[ch][SMP_W-1], offset_i[ch]};

    // Top two bits differ means overflow, clamp to -8192 / 8191
    assign sat = (sum[SUM_W-1] ^ sum[SUM_W-2])
               ? {sum[SUM_W-1], {(SMP_W-1){~sum[SUM_W-1]}}}
               : sum[SMP_W-1:0];

    assign dac_smp_o[ch] = sat;

    ////////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge adc_clk)
    begin
      if (!rst_n_i)
        dac_q <= DAC_CODE_ZERO;             // Mid-scale after reset
      else
        dac_q <= flip_code(sat);            // Back to negative slope
    end

    assign dac_dat_o[ch] = dac_q;

    // In-range sums leave saturation untouched
    a_sum_fits: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      (int'(level_i[ch]) + int'(offset_i[ch]) inside {[-8192:8191]})
        |-> int'($signed(sat)) == int'(level_i[ch]) + int'(offset_i[ch]));
  end

endmodule

// File: hw/rp_reg_bank.sv
`timescale 1ns/1ns

module rp_reg_bank
  import rp_pkg::*;
#(
  parameter int CNT_W = 32
)
(
  input  logic                          adc_clk,
  input  logic                          rst_n_i,
  input  axil_req_t                     axil_req_i,
  output axil_rsp_t                     axil_rsp_o,
  input  sample_t [NUM_CH-1:0]          adc_smp_i,
  input  logic    [NUM_EXP-1:0][CNT_W-1:0] cnt_i,
  output rp_cfg_t                       cfg_o,
  output logic    [NUM_EXP-1:0]         cnt_clr_o
);

  logic              aw_hs_q;   // Acceptance cycle of a write
  logic              b_vld_q;
  logic [1:0]        b_resp_q;
  logic              ar_hs_q;   // Acceptance cycle of a read
  logic              r_vld_q;
  logic [1:0]        r_resp_q;
  logic [AXI_DW-1:0] r_data_q;
  logic [AXI_DW-1:0] rd_mux;
  logic              wr_go;
  logic              rd_go;
  rp_cfg_t           cfg_q;
  logic [NUM_EXP-1:0] clr_q;

  // Region, then word within region
  function automatic logic addr_ok(input logic [AXI_AW-1:0] a);
    logic [3:0] word;
    word = a[5:2];
    case (a[7:6])
      RGN_HK:  addr_ok = (word <= 4'd3);  // ID, CTRL, ADC A/B
      RGN_DAC: addr_ok = (word <= 4'd3);  // Levels, offsets
      RGN_PWM: addr_ok = (word < NUM_PWM);
      default: addr_ok = (word < NUM_EXP);
    endcase
    addr_ok = addr_ok && (a[1:0] == 2'b00);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Write channel
  ////////////////////////////////////////////////////////////////////////////

  // AW and W taken together, blocked while a response waits
  assign wr_go = axil_req_i.awvalid & axil_req_i.wvalid & ~b_vld_q & ~aw_hs_q;

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      aw_hs_q <= 1'b0;
      b_vld_q <= 1'b0;
    end
    else
    begin
      aw_hs_q <= wr_go;                           // Single-cycle ready
      if (aw_hs_q)
        b_vld_q <= 1'b1;
      else if (axil_req_i.bready)
        b_vld_q <= 1'b0;
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (aw_hs_q)
      b_resp_q <= addr_ok(axil_req_i.awaddr) ? RESP_OKAY : RESP_SLVERR;
  end

  // Config update lands with bvalid
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      cfg_q <= '0;
      clr_q <= '0;
    end
    else
    begin
      clr_q <= '0;                                // Clear bits are pulses
      if (aw_hs_q)
      begin
        case (axil_req_i.awaddr)
          REG_CTRL:
          begin
            cfg_q.digital_loop <= axil_req_i.wdata[0];
            cfg_q.led          <= axil_req_i.wdata[15:8];
          end
          REG_DAC_LEVEL_A: cfg_q.dac_level[0]  <= axil_req_i.wdata[SMP_W-1:0];
          REG_DAC_LEVEL_B: cfg_q.dac_level[1]  <= axil_req_i.wdata[SMP_W-1:0];
          REG_DAC_OFS_A:   cfg_q.dac_offset[0] <= axil_req_i.wdata[SMP_W-1:0];
          REG_DAC_OFS_B:   cfg_q.dac_offset[1] <= axil_req_i.wdata[SMP_W-1:0];
          default: ;                              // ID and ADC are read-only
        endcase
        for (int i = 0; i < NUM_PWM; i++)
          if (axil_req_i.awaddr == REG_PWM + AXI_AW'(4 * i))
            cfg_q.pwm_duty[i] <= axil_req_i.wdata[7:0];
        for (int i = 0; i < NUM_EXP; i++)
          if (axil_req_i.awaddr == REG_CNT + AXI_AW'(4 * i))
            clr_q[i] <= 1'b1;                     // Any data clears
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read channel
  ////////////////////////////////////////////////////////////////////////////

  assign rd_go = axil_req_i.arvalid & ~r_vld_q & ~ar_hs_q;

  always_comb
  begin
    rd_mux = '0;                                  // Unmapped reads zero
    case (axil_req_i.araddr)
      REG_ID:          rd_mux = RP_ID;
      REG_CTRL:        rd_mux = {16'h0, cfg_q.led, 7'h0, cfg_q.digital_loop};
      REG_ADC_A:       rd_mux = AXI_DW'(adc_smp_i[0]);       // Sign-extended
      REG_ADC_B:       rd_mux = AXI_DW'(adc_smp_i[1]);
      REG_DAC_LEVEL_A: rd_mux = AXI_DW'(cfg_q.dac_level[0]);
      REG_DAC_LEVEL_B: rd_mux = AXI_DW'(cfg_q.dac_level[1]);
      REG_DAC_OFS_A:   rd_mux = AXI_DW'(cfg_q.dac_offset[0]);
      REG_DAC_OFS_B:   rd_mux = AXI_DW'(cfg_q.dac_offset[1]);
      default: ;
    endcase
    for (int i = 0; i < NUM_PWM; i++)
      if (axil_req_i.araddr == REG_PWM + AXI_AW'(4 * i))
        rd_mux = AXI_DW'(cfg_q.pwm_duty[i]);
    for (int i = 0; i < NUM_EXP; i++)
      if (axil_req_i.araddr == REG_CNT + AXI_AW'(4 * i))
        rd_mux = AXI_DW'(cnt_i[i]);               // Zero-extended
  end

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      ar_hs_q <= 1'b0;
      r_vld_q <= 1'b0;
    end
    else
    begin
      ar_hs_q <= rd_go;
      if (ar_hs_q)
        r_vld_q <= 1'b1;
      else if (axil_req_i.rready)
        r_vld_q <= 1'b0;
    end
  end

  // Read data captured once, held until rready
  always_ff @(posedge adc_clk)
  begin
    if (ar_hs_q)
    begin
      r_data_q <= rd_mux;
      r_resp_q <= addr_ok(axil_req_i.araddr) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  always_comb
  begin
    axil_rsp_o.awready = aw_hs_q;
    axil_rsp_o.wready  = aw_hs_q;
    axil_rsp_o.bresp   = b_resp_q;
    axil_rsp_o.bvalid  = b_vld_q;
    axil_rsp_o.arready = ar_hs_q;
    axil_rsp_o.rdata   = r_data_q;
    axil_rsp_o.rresp   = r_resp_q;
    axil_rsp_o.rvalid  = r_vld_q;
  end

  assign cfg_o     = cfg_q;
  assign cnt_clr_o = clr_q;

  a_bvalid_hold: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    axil_rsp_o.bvalid && !axil_req_i.bready |=> axil_rsp_o.bvalid);

  a_rdata_stable: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    axil_rsp_o.rvalid && !axil_req_i.rready
      |=> axil_rsp_o.rvalid && $stable(axil_rsp_o.rdata));

endmodule

// File: hw/rp_analog_top.sv
`timescale 1ns/1ns

module rp_analog_top
  import rp_pkg::*;
#(
  parameter int CNT_W = 32  // Edge counter width, 8 to 32
)
(
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  // Register port
  input  axil_req_t                axil_req_i,
  output axil_rsp_t                axil_rsp_o,
  // Analog pins
  input  adc_raw_t  [NUM_CH-1:0]   adc_dat_i,
  output dac_code_t [NUM_CH-1:0]   dac_dat_o,
  // Housekeeping pins
  output logic      [NUM_PWM-1:0]  pwm_o,
  input  logic      [NUM_EXP-1:0]  exp_i,
  output logic      [LED_W-1:0]    led_o
);

  rp_cfg_t                        cfg;
  logic    [NUM_EXP-1:0]          cnt_clr;   // One pulse per counter
  logic    [NUM_EXP-1:0][CNT_W-1:0] cnt;
  sample_t [NUM_CH-1:0]           adc_smp;   // After loopback select
  sample_t [NUM_CH-1:0]           dac_smp;   // Saturated, fed back

  ////////////////////////////////////////////////////////////////////////////
  // Registers and bus
  ////////////////////////////////////////////////////////////////////////////

  rp_reg_bank #(
    .CNT_W (CNT_W)
  ) u_reg_bank (
    .adc_clk    (adc_clk),
    .rst_n_i    (rst_n_i),
    .axil_req_i (axil_req_i),
    .axil_rsp_o (axil_rsp_o),
    .adc_smp_i  (adc_smp),
    .cnt_i      (cnt),
    .cfg_o      (cfg),
    .cnt_clr_o  (cnt_clr)
  );

  assign led_o = cfg.led;

  ////////////////////////////////////////////////////////////////////////////
  // Data path
  ////////////////////////////////////////////////////////////////////////////

  rp_adc_frontend u_adc (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .adc_dat_i (adc_dat_i),
    .loop_i    (cfg.digital_loop),
    .dac_smp_i (dac_smp),
    .adc_smp_o (adc_smp)
  );

  rp_dac_backend u_dac (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .level_i   (cfg.dac_level),
    .offset_i  (cfg.dac_offset),
    .dac_smp_o (dac_smp),
    .dac_dat_o (dac_dat_o)
  );

  rp_pwm u_pwm (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .duty_i  (cfg.pwm_duty),
    .pwm_o   (pwm_o)
  );

  rp_event_counter #(
    .CNT_W (CNT_W)
  ) u_cnt (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .exp_i   (exp_i),
    .clr_i   (cnt_clr),
    .cnt_o   (cnt)
  );

endmodule

// File: tb/tb_rp_analog_top.sv
`timescale 1ns/1ns

module tb_rp_analog_top
  import rp_pkg::*;
();

  localparam int CNT_W      = 32;
  localparam int RST_CYCLES = 16;
  // ~60 bus steps under 10 cycles, four PWM periods, pulse trains, 3x margin
  localparam int TIMEOUT_CYCLES = 5000;

  typedef enum int {OP_WR, OP_RD, OP_ADC, OP_PULSE, OP_PWM, OP_DAC, OP_LED} op_e;

  typedef struct {
    op_e         op;
    logic [7:0]  addr;   // Bus address, channel, or input mask
    logic [31:0] data;
    logic [31:0] exp;
    logic [1:0]  resp;   // Expected bresp / rresp
  } step_t;

  logic                     adc_clk = 1'b0;
  logic                     rst_n_i;
  axil_req_t                axil_req;
  axil_rsp_t                axil_rsp;
  adc_raw_t  [NUM_CH-1:0]   adc_dat;
  dac_code_t [NUM_CH-1:0]   dac_dat;
  logic      [NUM_PWM-1:0]  pwm;
  logic      [NUM_EXP-1:0]  exp_pins;
  logic      [LED_W-1:0]    led;

  step_t steps[$];
  int    err_cnt = 0;
  int    chk_cnt = 0;
  int    cycle_cnt = 0;
  int    seed_dummy;
  int    lvl [NUM_CH];       // Model of level registers
  int    ofs [NUM_CH];       // Model of offset registers

  rp_analog_top #(
    .CNT_W (CNT_W)
  ) DUT (
    .adc_clk    (adc_clk),
    .rst_n_i    (rst_n_i),
    .axil_req_i (axil_req),
    .axil_rsp_o (axil_rsp),
    .adc_dat_i  (adc_dat),
    .dac_dat_o  (dac_dat),
    .pwm_o      (pwm),
    .exp_i      (exp_pins),
    .led_o      (led)
  );

  always #50 adc_clk = ~adc_clk;  // 100 ns period

  // Watchdog
  always @(posedge adc_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic int to_int(input logic [13:0] w);
    return w[13] ? int'(w) - 16384 : int'(w);  // 14-bit signed
  endfunction

  // Clamp to the 14-bit range
  function automatic int sat_sum(input int a, input int b);
    int s;
    s = a + b;
    if (s > 8191)
      s = 8191;
    else if (s < -8192)
      s = -8192;
    return s;
  endfunction

  function automatic logic [13:0] neg_code(input int s);
    logic [13:0] w;
    w = s[13:0];
    return w ^ 14'h1FFF;                         // Sign kept, rest inverted
  endfunction

  // Top 14 bits, converted, sign-extended
  function automatic logic [31:0] adc_word(input logic [15:0] raw);
    logic [13:0] smp;
    smp = raw[15:2] ^ 14'h1FFF;
    return {{18{smp[13]}}, smp};
  endfunction

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp)
    begin
      $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic add_step(input op_e op, input logic [7:0] addr, input logic [31:0] data,
                          input logic [31:0] exp, input logic [1:0] resp);
    step_t s;
    s.op   = op;
    s.addr = addr;
    s.data = data;
    s.exp  = exp;
    s.resp = resp;
    steps.push_back(s);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // AXI4-Lite driver, called right after a rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    axil_req.awaddr  <= addr;
    axil_req.awvalid <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= 4'hF;
    axil_req.wvalid  <= 1'b1;
    do
      @(negedge adc_clk);
    while (!axil_rsp.awready);                   // Sample mid-cycle
    @(posedge adc_clk);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    axil_req.bready  <= 1'b1;
    do
      @(negedge adc_clk);
    while (!axil_rsp.bvalid);
    resp = axil_rsp.bresp;
    @(posedge adc_clk);
    axil_req.bready <= 1'b0;
  endtask

  task automatic bus_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    axil_req.araddr  <= addr;
    axil_req.arvalid <= 1'b1;
    do
      @(negedge adc_clk);
    while (!axil_rsp.arready);
    @(posedge adc_clk);
    axil_req.arvalid <= 1'b0;
    axil_req.rready  <= 1'b1;
    do
      @(negedge adc_clk);
    while (!axil_rsp.rvalid);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(posedge adc_clk);
    axil_req.rready <= 1'b0;
  endtask

  task automatic run_step(input step_t s);
    logic [1:0]  resp;
    logic [31:0] rdata;
    int          highs;
    case (s.op)
      OP_WR:
      begin
        bus_write(s.addr, s.data, resp);
        compare($sformatf("bresp at %02h", s.addr), 32'(resp), 32'(s.resp));
      end
      OP_RD:
      begin
        bus_read(s.addr, rdata, resp);
        compare($sformatf("rresp at %02h", s.addr), 32'(resp), 32'(s.resp));
        compare($sformatf("rdata at %02h", s.addr), rdata, s.exp);
      end
      OP_ADC:
      begin
        adc_dat[0] <= s.data[15:0];
        adc_dat[1] <= s.data[31:16];
        repeat (2) @(posedge adc_clk);           // Held two cycles
      end
      OP_PULSE:
        for (int n = 0; n < int'(s.data); n++)
        begin
          exp_pins <= s.addr[NUM_EXP-1:0];
          repeat (2) @(posedge adc_clk);
          exp_pins <= '0;
          repeat (2) @(posedge adc_clk);
        end
      OP_PWM:
      begin
        highs = 0;
        repeat (256)                             // One full period
        begin
          @(negedge adc_clk);
          if (pwm[s.addr[1:0]])
            highs++;
        end
        @(posedge adc_clk);
        compare($sformatf("pwm_o[%0d] high cycles", s.addr), 32'(highs), s.exp);
      end
      OP_DAC:
      begin
        @(posedge adc_clk);
        @(negedge adc_clk);
        compare($sformatf("dac_dat_o[%0d]", s.addr), 32'(dac_dat[s.addr[0]]), s.exp);
        @(posedge adc_clk);
      end
      default:
      begin
        @(negedge adc_clk);
        compare("led_o", 32'(led), s.exp);
        @(posedge adc_clk);
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_table();
    logic [15:0] raw_a;
    logic [15:0] raw_b;
    logic [7:0]  duty [NUM_PWM];
    logic [7:0]  led_val;
    int          n_a;
    int          n_b;
    add_step(OP_RD, REG_ID, 0, RP_ID, RESP_OKAY);
    add_step(OP_RD, 8'h10, 0, 0, RESP_SLVERR);   // Unmapped housekeeping word
    add_step(OP_WR, 8'h14, 32'hFFFF_FFFF, 0, RESP_SLVERR);
    add_step(OP_RD, REG_CTRL, 0, 0, RESP_OKAY);  // Unchanged
    // DAC: two random rounds, then overflow up and down
    for (int k = 0; k < 4; k++)
    begin
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
        lvl[ch] = to_int(14'($urandom));
        ofs[ch] = to_int(14'($urandom));
        if (k == 2)
        begin
          lvl[ch] = 6000 + int'($urandom % 2000);
          ofs[ch] = 8191 - int'($urandom % 100);
        end
        else if (k == 3)
        begin
          lvl[ch] = -6000 - int'($urandom % 2000);
          ofs[ch] = -8192 + int'($urandom % 100);
        end
        add_step(OP_WR, REG_DAC_LEVEL_A + 8'(4 * ch), 32'(lvl[ch]), 0, RESP_OKAY);
        add_step(OP_WR, REG_DAC_OFS_A + 8'(4 * ch), 32'(ofs[ch]), 0, RESP_OKAY);
      end
      for (int ch = 0; ch < NUM_CH; ch++)
        add_step(OP_DAC, 8'(ch), 0, 32'(neg_code(sat_sum(lvl[ch], ofs[ch]))), RESP_OKAY);
    end
    // ADC, then same top bits with low bits flipped
    for (int k = 0; k < 2; k++)
    begin
      raw_a = 16'($urandom);
      raw_b = 16'($urandom);
      for (int f = 0; f < 2; f++)
      begin
        add_step(OP_ADC, 0, {raw_b ^ 16'(3 * f), raw_a ^ 16'(3 * f)}, 0, RESP_OKAY);
        add_step(OP_RD, REG_ADC_A, 0, adc_word(raw_a), RESP_OKAY);
        add_step(OP_RD, REG_ADC_B, 0, adc_word(raw_b), RESP_OKAY);
      end
    end
    // Channel B back in range so A and B loop back different values
    lvl[1] = 1 + int'($urandom % 4095);
    add_step(OP_WR, REG_DAC_LEVEL_B, 32'(lvl[1]), 0, RESP_OKAY);
    // Loopback and LEDs
    led_val = 8'($urandom);
    add_step(OP_WR, REG_CTRL, {16'h0, led_val, 8'h01}, 0, RESP_OKAY);
    add_step(OP_RD, REG_ADC_A, 0, 32'(sat_sum(lvl[0], ofs[0])), RESP_OKAY);
    add_step(OP_RD, REG_ADC_B, 0, 32'(sat_sum(lvl[1], ofs[1])), RESP_OKAY);
    add_step(OP_LED, 0, 0, 32'(led_val), RESP_OKAY);
    add_step(OP_RD, REG_CTRL, 0, {16'h0, led_val, 8'h01}, RESP_OKAY);
    // PWM, output 3 at full duty
    for (int i = 0; i < NUM_PWM; i++)
    begin
      duty[i] = (i == 3) ? 8'hFF : 8'($urandom);
      add_step(OP_WR, REG_PWM + 8'(4 * i), 32'(duty[i]), 0, RESP_OKAY);
    end
    for (int i = 0; i < NUM_PWM; i++)
      add_step(OP_PWM, 8'(i), 0, 32'(duty[i]), RESP_OKAY);
    add_step(OP_RD, REG_PWM + 8'h08, 0, 32'(duty[2]), RESP_OKAY);
    // Edge counters
    n_a = 1 + int'($urandom % 4);
    n_b = 1 + int'($urandom % 4);
    add_step(OP_PULSE, 8'h0F, 32'(n_a), 0, RESP_OKAY);
    add_step(OP_PULSE, 8'h05, 32'(n_b), 0, RESP_OKAY);   // Inputs 0 and 2
    for (int i = 0; i < NUM_EXP; i++)
      add_step(OP_RD, REG_CNT + 8'(4 * i), 0, 32'((i % 2 == 0) ? n_a + n_b : n_a), RESP_OKAY);
    add_step(OP_WR, REG_CNT + 8'h04, 0, 0, RESP_OKAY);   // Clear input 1 only
    for (int i = 0; i < NUM_EXP; i++)
      add_step(OP_RD, REG_CNT + 8'(4 * i), 0,
               32'((i == 1) ? 0 : ((i % 2 == 0) ? n_a + n_b : n_a)), RESP_OKAY);
  endtask

  initial
  begin
    int  first_err;
    op_e cur_op;
    seed_dummy = $urandom(32'hacb4);
    rst_n_i    = 1'b0;
    axil_req   = '0;
    adc_dat    = '0;
    exp_pins   = '0;
    repeat (RST_CYCLES) @(posedge adc_clk);
    rst_n_i <= 1'b1;
    @(negedge adc_clk);                          // Still reset state
    first_err = err_cnt;
    compare("handshakes after reset", 32'({axil_rsp.awready, axil_rsp.wready,
            axil_rsp.bvalid, axil_rsp.arready, axil_rsp.rvalid}), 0);
    compare("dac_dat_o after reset", 32'(dac_dat), 32'({2{14'h1FFF}}));
    compare("pwm_o and led_o after reset", 32'({pwm, led}), 0);
    $display("step reset : %s", (err_cnt == first_err) ? "ok" : "FAILED");
    @(posedge adc_clk);
    build_table();
    foreach (steps[i])
    begin
      first_err = err_cnt;
      cur_op    = steps[i].op;
      run_step(steps[i]);
      $display("step %0d %s addr %02h : %s", i, cur_op.name(), steps[i].addr,
               (err_cnt == first_err) ? "ok" : "FAILED");
    end
    $display("%0d steps, %0d checks, %0d errors", steps.size() + 1, chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// File: rp_analog_top.f
hw/rp_pkg.sv
hw/rp_pwm.sv
hw/rp_event_counter.sv
hw/rp_adc_frontend.sv
hw/rp_dac_backend.sv
hw/rp_reg_bank.sv
hw/rp_analog_top.sv
tb/tb_rp_analog_top.sv

// File: Makefile
# Verilator simulation of the acquisition board glue

VERILATOR ?= verilator
TB_TOP    ?= tb_rp_analog_top
RTL_TOP   ?= rp_analog_top
FILELIST  ?= rp_analog_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@grep -qx '>>> PASS' $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) \
		hw/rp_pkg.sv hw/rp_pwm.sv hw/rp_event_counter.sv hw/rp_adc_frontend.sv \
		hw/rp_dac_backend.sv hw/rp_reg_bank.sv hw/rp_analog_top.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)
